// File: design/mac_pkg.sv
package mac_pkg;

  // Datapath widths
  localparam int ADDR_W = 16;  // Logical address and register word
  localparam int LA_W   = 14;  // Physical address bits 23..10
  localparam int SEG_W  = 8;
  localparam int PT_W   = 2;   // Page table number
  localparam int CMD_W  = 5;   // Microcode command field

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [LA_W-1:0]   la_t;
  typedef logic [SEG_W-1:0]  seg_t;
  typedef logic [PT_W-1:0]   pt_t;
  typedef logic [CMD_W-1:0]  cmd_t;

  // Base register for the address adder
  typedef enum logic [2:0] {
    OP_PR,   // Program register, instruction load only
    OP_RB,   // Microcode register B
    OP_BR,   // ALU B register
    OP_XR,   // X register
    OP_LCA   // Last cycle address
  } opsel_t;

  // Microcode commands on cscomm
  localparam cmd_t CMD_NOP     = 5'd0;
  localparam cmd_t CMD_EA_RB   = 5'd1;
  localparam cmd_t CMD_EA_BR   = 5'd2;
  localparam cmd_t CMD_EA_XR   = 5'd3;
  localparam cmd_t CMD_EA_LCA  = 5'd4;
  localparam cmd_t CMD_LD_CTL  = 5'd8;   // Target picked by cmis
  localparam cmd_t CMD_EXM_ON  = 5'd9;
  localparam cmd_t CMD_EXM_OFF = 5'd10;

  // Control register targets, cmis under CMD_LD_CTL
  localparam logic [1:0] CTL_PCR  = 2'd0;
  localparam logic [1:0] CTL_SEG  = 2'd1;
  localparam logic [1:0] CTL_XPT  = 2'd2;
  localparam logic [1:0] CTL_ECCR = 2'd3;

  // PCR field positions
  localparam int RING_LSB = 0;  // 2-bit ring
  localparam int NPT_LSB  = 7;  // Normal page table
  localparam int APT_LSB  = 9;  // Alternate page table

  // Shadow memory detection
  localparam logic [7:0] SHADOW_PAGE = 8'hFF;  // Top address byte
  localparam logic [1:0] SHADOW_RING = 2'd3;   // Ring without shadow

endpackage

// File: design/mac_decode.sv
`timescale 1ns/1ps

module mac_decode (
  input  logic            sysclk,
  input  logic            rst,
  input  logic            mclk,     // One-cycle microcycle enable
  input  mac_pkg::cmd_t   cscomm,   // Microcode command field
  input  logic [1:0]      cmis,     // cds or control target
  input  logic            ilcs_n,   // Instruction load, active low
  input  logic            wr3,      // Write strobe for PCR, seg, xpt
  input  logic            wr7,      // Write strobe for ECCR
  output mac_pkg::opsel_t opsel,    // Adder base select
  output logic            cds,      // Add displacement
  output logic            addr_ld,  // Address register load pulse
  output logic            fetch,    // Address load is an instruction fetch
  output logic            ld_pcr,
  output logic            ld_seg,
  output logic            ld_xpt,
  output logic            ld_eccr,
  output logic            exm       // Examine mode level
);

  logic ilcs;      // Instruction load, active high
  logic addr_cmd;  // One of the four EA commands
  logic ctl_cmd;   // Control register load
  logic exm_on;
  logic exm_off;

  assign ilcs = ~ilcs_n;

  // Command field decode
  always_comb begin
    opsel    = mac_pkg::OP_PR;
    addr_cmd = 1'b0;
    ctl_cmd  = 1'b0;
    exm_on   = 1'b0;
    exm_off  = 1'b0;
    case (cscomm)
      mac_pkg::CMD_EA_RB: begin
        opsel    = mac_pkg::OP_RB;
        addr_cmd = 1'b1;
      end
      mac_pkg::CMD_EA_BR: begin
        opsel    = mac_pkg::OP_BR;
        addr_cmd = 1'b1;
      end
      mac_pkg::CMD_EA_XR: begin
        opsel    = mac_pkg::OP_XR;
        addr_cmd = 1'b1;
      end
      mac_pkg::CMD_EA_LCA: begin
        opsel    = mac_pkg::OP_LCA;  // Relative to previous cycle
        addr_cmd = 1'b1;
      end
      mac_pkg::CMD_LD_CTL:  ctl_cmd = 1'b1;
      mac_pkg::CMD_EXM_ON:  exm_on  = 1'b1;
      mac_pkg::CMD_EXM_OFF: exm_off = 1'b1;
      mac_pkg::CMD_NOP:     ;  // Idle microcycle
      default:              ;  // Unused codes act as NOP
    endcase
    // Instruction load wins over the command field
    if (ilcs) begin
      opsel    = mac_pkg::OP_PR;
      addr_cmd = 1'b0;
      ctl_cmd  = 1'b0;
      exm_on   = 1'b0;
      exm_off  = 1'b0;
    end
  end

  assign cds     = addr_cmd & cmis[0];  // Never set on a fetch
  assign addr_ld = mclk & (addr_cmd | ilcs);
  assign fetch   = mclk & ilcs;

  // Control loads need the command, the strobe and the target
  assign ld_pcr  = mclk & ctl_cmd & wr3 & (cmis == mac_pkg::CTL_PCR);
  assign ld_seg  = mclk & ctl_cmd & wr3 & (cmis == mac_pkg::CTL_SEG);
  assign ld_xpt  = mclk & ctl_cmd & wr3 & (cmis == mac_pkg::CTL_XPT);
  assign ld_eccr = mclk & ctl_cmd & wr7 & (cmis == mac_pkg::CTL_ECCR);  // wr7 only

  // Examine mode latch
  always_ff @(posedge sysclk) begin
    if (rst) begin
      exm <= 1'b0;
    end else if (mclk && exm_on) begin
      exm <= 1'b1;
    end else if (mclk && exm_off) begin
      exm <= 1'b0;  // Back to PCR page tables
    end
  end

  // At most one register bank or address load per microcycle
  assert property (@(posedge sysclk) disable iff (rst)
    $onehot0({addr_ld, ld_pcr, ld_seg, ld_xpt, ld_eccr}));

endmodule

// File: design/mac_addr_gen.sv
`timescale 1ns/1ps

module mac_addr_gen (
  input  logic            sysclk,
  input  logic            rst,
  input  logic            addr_ld,  // Load ica, shift old ica to lca
  input  logic            cds,      // Add cd as displacement
  input  mac_pkg::opsel_t opsel,
  input  mac_pkg::addr_t  pr,       // Program register
  input  mac_pkg::addr_t  rb,       // Microcode register B
  input  mac_pkg::addr_t  br,       // ALU B register
  input  mac_pkg::addr_t  xr,       // X register
  input  mac_pkg::addr_t  cd,       // CPU data word
  output mac_pkg::addr_t  ea_next,  // Adder output, combinational
  output mac_pkg::addr_t  nlca,
  output logic [9:0]      mca
);

  mac_pkg::addr_t base;  // Selected base operand
  mac_pkg::addr_t disp;  // Displacement or zero
  mac_pkg::addr_t ica;   // Current cycle address
  mac_pkg::addr_t lca;   // Last cycle address

  // Base operand mux
  always_comb begin
    case (opsel)
      mac_pkg::OP_PR:  base = pr;
      mac_pkg::OP_RB:  base = rb;
      mac_pkg::OP_BR:  base = br;
      mac_pkg::OP_XR:  base = xr;
      mac_pkg::OP_LCA: base = lca;
      default:         base = pr;  // Unreachable
    endcase
  end

  assign disp = cds ? cd : '0;

  // 16-bit add, carry out dropped
  assign ea_next = base + disp;

  // Cycle address pipeline
  always_ff @(posedge sysclk) begin
    if (rst) begin
      ica <= '0;
      lca <= '0;
    end else if (addr_ld) begin
      ica <= ea_next;
      lca <= ica;  // Previous address kept for OP_LCA
    end
  end

  assign nlca = ica;
  assign mca  = ica[9:0];  // Word offset within the page

  // Decoder must only produce defined base selects
  assert property (@(posedge sysclk) disable iff (rst)
    !$isunknown(opsel) && (opsel inside {mac_pkg::OP_PR, mac_pkg::OP_RB,
      mac_pkg::OP_BR, mac_pkg::OP_XR, mac_pkg::OP_LCA}));

endmodule

// File: design/mac_ctl_regs.sv
`timescale 1ns/1ps

module mac_ctl_regs (
  input  logic           sysclk,
  input  logic           rst,
  input  logic           ld_pcr,   // Load pulses from the decoder
  input  logic           ld_seg,
  input  logic           ld_xpt,
  input  logic           ld_eccr,
  input  mac_pkg::addr_t fidbo,    // Internal data bus
  input  mac_pkg::addr_t cd,       // CPU data, bit 0 feeds ECCR
  output mac_pkg::addr_t pcr,      // Program control register
  output mac_pkg::seg_t  seg,      // Segment register
  output mac_pkg::pt_t   xpt,      // Examine page table
  output logic           eccr      // ECC control flag
);

  // PCR holds ring and page table numbers
  always_ff @(posedge sysclk) begin
    if (rst) begin
      pcr <= '0;
    end else if (ld_pcr) begin
      pcr <= fidbo;
    end
  end

  // Segment from the low byte of fidbo
  always_ff @(posedge sysclk) begin
    if (rst) begin
      seg <= '0;
    end else if (ld_seg) begin
      seg <= fidbo[mac_pkg::SEG_W-1:0];
    end
  end

  // Examine page table, used while exm is set
  always_ff @(posedge sysclk) begin
    if (rst) begin
      xpt <= '0;
    end else if (ld_xpt) begin
      xpt <= fidbo[mac_pkg::PT_W-1:0];
    end
  end

  always_ff @(posedge sysclk) begin
    if (rst) begin
      eccr <= 1'b0;
    end else if (ld_eccr) begin
      eccr <= cd[0];  // Single flag bit
    end
  end

endmodule

// File: design/mac_la_map.sv
`timescale 1ns/1ps

module mac_la_map (
  input  logic           sysclk,
  input  logic           rst,
  input  logic           addr_ld,  // Address load pulse
  input  logic           fetch,    // Load is an instruction fetch
  input  logic           csmreq,   // Memory request this cycle
  input  logic           poni,     // Memory protection on
  input  logic           ptm,      // Alternate page table enable
  input  logic           exm,      // Examine mode
  input  mac_pkg::addr_t ea_next,  // Logical address being loaded
  input  mac_pkg::addr_t pcr,
  input  mac_pkg::seg_t  seg,
  input  mac_pkg::pt_t   xpt,
  output mac_pkg::la_t   la,       // Physical address bits 23..10
  output logic           lshadow,
  output logic           vex
);

  logic          la_ld;        // Latch enable
  mac_pkg::pt_t  pt_sel;       // Chosen page table
  logic [1:0]    ring;
  mac_pkg::la_t  la_next;
  logic          shadow_next;
  logic          vex_next;

  assign la_ld = addr_ld & csmreq;
  assign ring  = pcr[mac_pkg::RING_LSB +: 2];

  // Page table priority: examine, alternate, normal
  always_comb begin
    if (exm) begin
      pt_sel = xpt;
    end else if (ptm && ea_next[mac_pkg::ADDR_W-1]) begin
      pt_sel = pcr[mac_pkg::APT_LSB +: mac_pkg::PT_W];  // Upper half of space
    end else begin
      pt_sel = pcr[mac_pkg::NPT_LSB +: mac_pkg::PT_W];
    end
  end

  // Unmapped mode passes the page number straight through
  assign la_next = poni ? {pt_sel, seg[5:0], ea_next[15:10]}
                        : {8'b0, ea_next[15:10]};

  // Shadow page FF, except in ring 3
  assign shadow_next = poni && (ea_next[15:8] == mac_pkg::SHADOW_PAGE) &&
                       (ring != mac_pkg::SHADOW_RING);

  assign vex_next = poni & fetch & (seg == '0);  // Fetch from segment zero

  // Address and flags latched together
  always_ff @(posedge sysclk) begin
    if (rst) begin
      la      <= '0;
      lshadow <= 1'b0;
      vex     <= 1'b0;
    end else if (la_ld) begin
      la      <= la_next;
      lshadow <= shadow_next;
      vex     <= vex_next;
    end
  end

  // Without protection no page table or segment bits reach la
  assert property (@(posedge sysclk) disable iff (rst)
    (la_ld && !poni) |=> (la[mac_pkg::LA_W-1:6] == '0));

endmodule

// File: design/mac_top.sv
`timescale 1ns/1ps

module mac_top (
  input  logic           sysclk,
  input  logic           rst,
  input  logic           mclk,     // Microcycle enable
  input  logic           csmreq,   // Memory request
  input  logic           ilcs_n,   // Instruction load, active low
  input  logic           poni,     // Memory protection on
  input  logic           ptm,      // Alternate page table mode
  input  logic           wr3,
  input  logic           wr7,
  input  mac_pkg::cmd_t  cscomm,   // Microcode command
  input  logic [1:0]     cmis,     // Microcode misc
  input  mac_pkg::addr_t rb,
  input  mac_pkg::addr_t cd,
  input  mac_pkg::addr_t fidbo,
  input  mac_pkg::addr_t pr,
  input  mac_pkg::addr_t br,
  input  mac_pkg::addr_t xr,
  output logic           eccr,
  output logic           lshadow,
  output logic           vex,
  output mac_pkg::la_t   la,
  output logic [9:0]     mca,
  output mac_pkg::addr_t nlca,
  output mac_pkg::addr_t pcr
);

  // Decoder outputs
  mac_pkg::opsel_t opsel;
  logic            cds;
  logic            addr_ld;
  logic            fetch;
  logic            ld_pcr;
  logic            ld_seg;
  logic            ld_xpt;
  logic            ld_eccr;
  logic            exm;

  mac_pkg::addr_t  ea_next;  // Adder to address latch
  mac_pkg::seg_t   seg;
  mac_pkg::pt_t    xpt;

  mac_decode mac_decode_i (
    .sysclk  (sysclk),
    .rst     (rst),
    .mclk    (mclk),
    .cscomm  (cscomm),
    .cmis    (cmis),
    .ilcs_n  (ilcs_n),
    .wr3     (wr3),
    .wr7     (wr7),
    .opsel   (opsel),
    .cds     (cds),
    .addr_ld (addr_ld),
    .fetch   (fetch),
    .ld_pcr  (ld_pcr),
    .ld_seg  (ld_seg),
    .ld_xpt  (ld_xpt),
    .ld_eccr (ld_eccr),
    .exm     (exm)
  );

  mac_addr_gen mac_addr_gen_i (
    .sysclk  (sysclk),
    .rst     (rst),
    .addr_ld (addr_ld),
    .cds     (cds),
    .opsel   (opsel),
    .pr      (pr),
    .rb      (rb),
    .br      (br),
    .xr      (xr),
    .cd      (cd),
    .ea_next (ea_next),
    .nlca    (nlca),
    .mca     (mca)
  );

  mac_ctl_regs mac_ctl_regs_i (
    .sysclk  (sysclk),
    .rst     (rst),
    .ld_pcr  (ld_pcr),
    .ld_seg  (ld_seg),
    .ld_xpt  (ld_xpt),
    .ld_eccr (ld_eccr),
    .fidbo   (fidbo),
    .cd      (cd),     // ECCR data bit
    .pcr     (pcr),    // Also a top-level output
    .seg     (seg),
    .xpt     (xpt),
    .eccr    (eccr)
  );

  mac_la_map mac_la_map_i (
    .sysclk  (sysclk),
    .rst     (rst),
    .addr_ld (addr_ld),
    .fetch   (fetch),
    .csmreq  (csmreq),
    .poni    (poni),
    .ptm     (ptm),
    .exm     (exm),
    .ea_next (ea_next),
    .pcr     (pcr),
    .seg     (seg),
    .xpt     (xpt),
    .la      (la),
    .lshadow (lshadow),
    .vex     (vex)
  );

endmodule

// File: tests/mac_tb.sv
`timescale 1ns/1ps

module mac_tb;

  logic           sysclk;
  logic           rst;
  logic           mclk;
  logic           csmreq;
  logic           ilcs_n;
  logic           poni;
  logic           ptm;
  logic           wr3;
  logic           wr7;
  mac_pkg::cmd_t  cscomm;
  logic [1:0]     cmis;
  mac_pkg::addr_t rb;
  mac_pkg::addr_t cd;
  mac_pkg::addr_t fidbo;
  mac_pkg::addr_t pr;
  mac_pkg::addr_t br;
  mac_pkg::addr_t xr;
  logic           eccr;
  logic           lshadow;
  logic           vex;
  mac_pkg::la_t   la;
  logic [9:0]     mca;
  mac_pkg::addr_t nlca;
  mac_pkg::addr_t pcr;

  // Reference state follows the rules on every mclk pulse
  mac_pkg::addr_t m_ica;
  mac_pkg::addr_t m_lca;
  mac_pkg::addr_t m_pcr;
  mac_pkg::seg_t  m_seg;
  mac_pkg::pt_t   m_xpt;
  mac_pkg::la_t   m_la;
  logic           m_exm;
  logic           m_eccr;
  logic           m_shadow;
  logic           m_vex;

  int unsigned lcg_state = 6;
  int unsigned tick_cnt  = 0;  // Rising edges seen

  mac_top mac_top_i (
    .sysclk(sysclk), .rst(rst), .mclk(mclk), .csmreq(csmreq), .ilcs_n(ilcs_n),
    .poni(poni), .ptm(ptm), .wr3(wr3), .wr7(wr7), .cscomm(cscomm), .cmis(cmis),
    .rb(rb), .cd(cd), .fidbo(fidbo), .pr(pr), .br(br), .xr(xr),
    .eccr(eccr), .lshadow(lshadow), .vex(vex), .la(la), .mca(mca),
    .nlca(nlca), .pcr(pcr)
  );

  initial begin
    sysclk = 1'b0;
    forever #5 sysclk = ~sysclk;
  end

  always @(posedge sysclk) tick_cnt <= tick_cnt + 1;

  function automatic mac_pkg::addr_t lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:15];  // Upper bits have the longer period
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1);
  endtask

  // Polls at even times and returns 1 ns after the next rising edge
  task automatic next_cycle();
    int unsigned start;
    int          guard;
    start = tick_cnt;
    guard = 0;
    while (tick_cnt == start && guard < 20) begin
      #2;
      guard++;
    end
    if (tick_cnt == start) abort_run("Timeout: no rising clock edge seen");
  endtask

  task automatic check_addr(input string name, input mac_pkg::addr_t exp, act);
    if (act !== exp) abort_run($sformatf("FAILED %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_la(input string name, input mac_pkg::la_t exp, act);
    if (act !== exp) abort_run($sformatf("FAILED %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_bit(input string name, input logic exp, act);
    if (act !== exp) abort_run($sformatf("FAILED %s expected %b actual %b", name, exp, act));
  endtask

  // Page table number, segment and page number
  function automatic mac_pkg::la_t ref_la(input mac_pkg::addr_t ea);
    mac_pkg::pt_t pt;
    if (m_exm) pt = m_xpt;
    else if (ptm && ea[15]) pt = m_pcr[mac_pkg::APT_LSB +: mac_pkg::PT_W];
    else pt = m_pcr[mac_pkg::NPT_LSB +: mac_pkg::PT_W];
    if (poni) return {pt, m_seg[5:0], ea[15:10]};
    return {8'h00, ea[15:10]};
  endfunction

  // One microcycle with mclk while the reference model follows the command
  task automatic pulse(input mac_pkg::cmd_t cmd, input logic [1:0] mis);
    mac_pkg::addr_t base;
    mac_pkg::addr_t ea;
    logic           is_ea;
    cscomm = cmd;
    cmis   = mis;
    mclk   = 1'b1;
    is_ea  = cmd inside {mac_pkg::CMD_EA_RB, mac_pkg::CMD_EA_BR,
                         mac_pkg::CMD_EA_XR, mac_pkg::CMD_EA_LCA};
    if (!ilcs_n || is_ea) begin
      if (!ilcs_n) base = pr;  // Fetch wins
      else if (cmd == mac_pkg::CMD_EA_RB) base = rb;
      else if (cmd == mac_pkg::CMD_EA_BR) base = br;
      else if (cmd == mac_pkg::CMD_EA_XR) base = xr;
      else base = m_lca;
      ea = base + ((ilcs_n && mis[0]) ? cd : 16'h0000);
      if (csmreq) begin
        m_la     = ref_la(ea);
        m_shadow = poni && ea[15:8] == mac_pkg::SHADOW_PAGE &&
                   m_pcr[mac_pkg::RING_LSB +: 2] != mac_pkg::SHADOW_RING;
        m_vex    = poni && !ilcs_n && m_seg == 8'h00;
      end
      m_lca = m_ica;
      m_ica = ea;
    end else if (cmd == mac_pkg::CMD_LD_CTL) begin
      if (wr3 && mis == mac_pkg::CTL_PCR) m_pcr = fidbo;
      if (wr3 && mis == mac_pkg::CTL_SEG) m_seg = fidbo[7:0];
      if (wr3 && mis == mac_pkg::CTL_XPT) m_xpt = fidbo[1:0];
      if (wr7 && mis == mac_pkg::CTL_ECCR) m_eccr = cd[0];
    end else if (cmd == mac_pkg::CMD_EXM_ON) begin
      m_exm = 1'b1;
    end else if (cmd == mac_pkg::CMD_EXM_OFF) begin
      m_exm = 1'b0;
    end
    next_cycle();  // Result visible one edge later
    mclk   = 1'b0;
    cscomm = mac_pkg::CMD_NOP;
  endtask

  task automatic check_outputs(input string tname);
    check_addr({tname, " nlca"}, m_ica, nlca);
    check_addr({tname, " mca"}, {6'b0, m_ica[9:0]}, {6'b0, mca});
    check_addr({tname, " pcr"}, m_pcr, pcr);
    check_la({tname, " la"}, m_la, la);
    check_bit({tname, " eccr"}, m_eccr, eccr);
    check_bit({tname, " lshadow"}, m_shadow, lshadow);
    check_bit({tname, " vex"}, m_vex, vex);
  endtask

  task automatic test_reset();
    check_la("test_reset la", '0, la);
    check_addr("test_reset nlca", '0, nlca);
    check_addr("test_reset mca", '0, {6'b0, mca});
    check_addr("test_reset pcr", '0, pcr);
    check_bit("test_reset eccr", 1'b0, eccr);
    check_bit("test_reset lshadow", 1'b0, lshadow);
    check_bit("test_reset vex", 1'b0, vex);
  endtask

  task automatic test_effective_address();
    mac_pkg::cmd_t cmds[4];
    cmds = '{mac_pkg::CMD_EA_RB, mac_pkg::CMD_EA_BR, mac_pkg::CMD_EA_XR, mac_pkg::CMD_EA_LCA};
    csmreq = 1'b1;
    for (int c = 0; c < 4; c++) begin
      for (int d = 0; d < 2; d++) begin
        rb = lcg_next();
        br = lcg_next();
        xr = lcg_next();
        cd = lcg_next();
        pulse(cmds[c], {1'b0, d[0]});
        check_outputs("test_effective_address");
      end
    end
    pulse(mac_pkg::CMD_EA_LCA, 2'b01);  // Second LCA step uses lca from above
    check_outputs("test_effective_address");
  endtask

  task automatic test_instruction_load();
    pr     = lcg_next();
    fidbo  = lcg_next();
    ilcs_n = 1'b0;
    wr3    = 1'b1;
    pulse(mac_pkg::CMD_LD_CTL, mac_pkg::CTL_PCR);  // PCR write is overridden
    check_addr("test_instruction_load nlca", pr, nlca);
    check_outputs("test_instruction_load");
    pr = lcg_next();
    pulse(mac_pkg::CMD_EA_XR, 2'b01);  // No displacement on a fetch
    check_addr("test_instruction_load nlca", pr, nlca);
    check_outputs("test_instruction_load");
    ilcs_n = 1'b1;
    wr3    = 1'b0;
  endtask

  task automatic test_control_loads();
    fidbo = lcg_next();
    wr7   = 1'b1;
    pulse(mac_pkg::CMD_LD_CTL, mac_pkg::CTL_PCR);  // Wrong strobe
    check_outputs("test_control_loads");
    wr3 = 1'b1;
    wr7 = 1'b0;
    pulse(mac_pkg::CMD_LD_CTL, mac_pkg::CTL_PCR);
    check_addr("test_control_loads pcr", fidbo, pcr);
    cd = 16'h0001;
    pulse(mac_pkg::CMD_LD_CTL, mac_pkg::CTL_ECCR);  // wr3 does not reach ECCR
    check_bit("test_control_loads eccr", 1'b0, eccr);
    wr3 = 1'b0;
    wr7 = 1'b1;
    pulse(mac_pkg::CMD_LD_CTL, mac_pkg::CTL_SEG);   // Target mismatch
    check_bit("test_control_loads eccr", 1'b0, eccr);
    pulse(mac_pkg::CMD_LD_CTL, mac_pkg::CTL_ECCR);
    check_bit("test_control_loads eccr", 1'b1, eccr);
    check_outputs("test_control_loads");
    // Command held without mclk
    wr3    = 1'b1;
    fidbo  = lcg_next();
    cscomm = mac_pkg::CMD_LD_CTL;
    cmis   = mac_pkg::CTL_PCR;
    next_cycle();
    check_outputs("test_control_loads");
    fidbo = 16'h002A;
    pulse(mac_pkg::CMD_LD_CTL, mac_pkg::CTL_SEG);
    fidbo = 16'h0003;
    pulse(mac_pkg::CMD_LD_CTL, mac_pkg::CTL_XPT);
    wr3 = 1'b0;
    wr7 = 1'b0;
  endtask

  task automatic test_address_map();
    csmreq = 1'b1;
    poni   = 1'b0;
    rb     = lcg_next();
    pulse(mac_pkg::CMD_EA_RB, 2'b00);
    check_la("test_address_map la", {8'h00, rb[15:10]}, la);
    csmreq = 1'b0;
    rb     = lcg_next();
    pulse(mac_pkg::CMD_EA_RB, 2'b00);  // No request so la holds
    check_outputs("test_address_map");
    csmreq = 1'b1;
    poni   = 1'b1;
    wr3    = 1'b1;
    fidbo  = 16'h0480;  // APT 2, NPT 1, ring 0
    pulse(mac_pkg::CMD_LD_CTL, mac_pkg::CTL_PCR);
    wr3 = 1'b0;
    rb  = 16'h8C00;
    pulse(mac_pkg::CMD_EA_RB, 2'b00);
    check_la("test_address_map la", {2'd1, 6'h2A, 6'h23}, la);
    ptm = 1'b1;
    pulse(mac_pkg::CMD_EA_RB, 2'b00);  // Alternate table
    check_la("test_address_map la", {2'd2, 6'h2A, 6'h23}, la);
    rb = 16'h4C00;
    pulse(mac_pkg::CMD_EA_RB, 2'b00);
    check_la("test_address_map la", {2'd1, 6'h2A, 6'h13}, la);
    pulse(mac_pkg::CMD_EXM_ON, 2'b00);
    rb = 16'h8C00;
    pulse(mac_pkg::CMD_EA_RB, 2'b00);  // Examine table wins
    check_la("test_address_map la", {2'd3, 6'h2A, 6'h23}, la);
    pulse(mac_pkg::CMD_EXM_OFF, 2'b00);
    for (int i = 0; i < 6; i++) begin
      ptm = i[0];
      rb  = lcg_next();
      pulse(mac_pkg::CMD_EA_RB, 2'b00);
      check_outputs("test_address_map");
    end
    ptm = 1'b0;
  endtask

  task automatic test_flags();
    rb = 16'hFF40;
    pulse(mac_pkg::CMD_EA_RB, 2'b00);
    check_bit("test_flags lshadow", 1'b1, lshadow);
    wr3   = 1'b1;
    fidbo = 16'h0483;  // Ring 3
    pulse(mac_pkg::CMD_LD_CTL, mac_pkg::CTL_PCR);
    pulse(mac_pkg::CMD_EA_RB, 2'b00);
    check_bit("test_flags lshadow", 1'b0, lshadow);
    fidbo = 16'h0000;
    pulse(mac_pkg::CMD_LD_CTL, mac_pkg::CTL_SEG);
    wr3    = 1'b0;
    ilcs_n = 1'b0;
    pr     = lcg_next();
    pulse(mac_pkg::CMD_NOP, 2'b00);
    check_bit("test_flags vex", 1'b1, vex);
    ilcs_n = 1'b1;
    pulse(mac_pkg::CMD_EA_RB, 2'b00);  // Not a fetch
    check_bit("test_flags vex", 1'b0, vex);
    wr3   = 1'b1;
    fidbo = 16'h0005;
    pulse(mac_pkg::CMD_LD_CTL, mac_pkg::CTL_SEG);
    wr3    = 1'b0;
    ilcs_n = 1'b0;
    pulse(mac_pkg::CMD_NOP, 2'b00);
    check_bit("test_flags vex", 1'b0, vex);
    check_outputs("test_flags");
    ilcs_n = 1'b1;
  endtask

  initial begin
    rst    = 1'b1;
    mclk   = 1'b0;
    csmreq = 1'b0;
    ilcs_n = 1'b1;
    poni   = 1'b0;
    ptm    = 1'b0;
    wr3    = 1'b0;
    wr7    = 1'b0;
    cscomm = mac_pkg::CMD_NOP;
    cmis   = 2'b00;
    {rb, cd, fidbo, pr, br, xr} = '0;
    {m_ica, m_lca, m_pcr} = '0;
    {m_seg, m_xpt, m_la} = '0;
    {m_exm, m_eccr, m_shadow, m_vex} = '0;
    next_cycle();
    next_cycle();
    rst = 1'b0;
    test_reset();
    test_effective_address();
    test_instruction_load();
    test_control_loads();
    test_address_map();
    test_flags();
    $display("No errors");
    $finish;
  end

endmodule

// File: filelist.f
design/mac_pkg.sv
design/mac_decode.sv
design/mac_addr_gen.sv
design/mac_ctl_regs.sv
design/mac_la_map.sv
design/mac_top.sv
tests/mac_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the MAC testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -sv --timescale 1ns/1ps \
  --top-module mac_tb -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vmac_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Errors found" "$LOG"; then
  echo "Simulation FAILED"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

echo "Simulation PASSED"
exit 0
